// ==== hw/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// pc increment for sequential flow
`define RV_INSN_STEP 32'd4

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // same codes as funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_op_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_WAIT_INSN,
    ST_EXECUTE,
    ST_CHECK_PC,
    ST_WAIT_MEM,
    ST_WRITEBACK,
    ST_TRAP
  } cpu_state_e;

  typedef struct packed {
    opcode_e             opcode;
    alu_op_e             alu_op;
    branch_op_e          branch_op;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
    logic                use_imm;
    logic                legal;
    logic                writes_rd;
  } decoded_insn_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] rd_value;
    logic [`RV_XLEN-1:0] target_pc;
    logic [`RV_XLEN-1:0] mem_addr;
    logic                pc_misaligned;
    logic                addr_misaligned;
  } exec_result_t;

  typedef struct packed {
    logic                  valid;
    logic                  instr;
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN/8-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic                ready;
    logic [`RV_XLEN-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== hw/rv_decoder.sv ====
`include "rv_defines.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic [`RV_XLEN-1:0] insn,
  output decoded_insn_t       dec
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  function automatic alu_op_e alu_select(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.opcode = opcode_e'(insn[6:0]);
    dec.rd = insn[11:7];
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.branch_op = branch_op_e'(funct3);
    dec.alu_op = ALU_ADD;
    case (dec.opcode)
      OPC_LUI, OPC_AUIPC: begin
        dec.imm = imm_u;
        dec.legal = 1'b1;
        dec.writes_rd = 1'b1;
      end
      OPC_JAL: begin
        dec.imm = imm_j;
        dec.legal = 1'b1;
        dec.writes_rd = 1'b1;
      end
      OPC_JALR: begin
        dec.imm = imm_i;
        dec.legal = (funct3 == 3'b000);
        dec.writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        dec.legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      // narrower widths than a word trap
      OPC_LOAD: begin
        dec.imm = imm_i;
        dec.legal = (funct3 == 3'b010);
        dec.writes_rd = 1'b1;
      end
      OPC_STORE: begin
        dec.imm = imm_s;
        dec.legal = (funct3 == 3'b010);
      end
      OPC_OP_IMM: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        dec.alu_op = alu_select(funct3, (funct3 == 3'b101) && insn[30]);
        if (funct3 == 3'b001) begin
          dec.legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec.legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          dec.legal = 1'b1;
        end
      end
      OPC_OP: begin
        dec.writes_rd = 1'b1;
        dec.alu_op = alu_select(funct3, insn[30]);
        dec.legal = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      // ecall and ebreak end up in the trap state
      OPC_SYSTEM: dec.legal = 1'b0;
      default:    dec.legal = 1'b0;
    endcase
  end

endmodule

// ==== hw/rv_execute.sv ====
`include "rv_defines.svh"

module rv_execute
  import rv_pkg::*;
(
  input  decoded_insn_t       dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_value,
  input  logic [`RV_XLEN-1:0] rs2_value,
  output exec_result_t        res
);

  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] link;
  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] rs1_rel;
  logic [4:0] shamt;
  logic taken;

  assign op_b = dec.use_imm ? dec.imm : rs2_value;
  assign shamt = op_b[4:0];
  assign link = pc + `RV_INSN_STEP;
  assign pc_rel = pc + dec.imm;
  // shared by loads, stores and jalr
  assign rs1_rel = rs1_value + dec.imm;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_out = rs1_value + op_b;
      ALU_SUB:  alu_out = rs1_value - op_b;
      ALU_SLL:  alu_out = rs1_value << shamt;
      ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_value) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, rs1_value < op_b};
      ALU_XOR:  alu_out = rs1_value ^ op_b;
      ALU_SRL:  alu_out = rs1_value >> shamt;
      ALU_SRA:  alu_out = $signed(rs1_value) >>> shamt;
      ALU_OR:   alu_out = rs1_value | op_b;
      ALU_AND:  alu_out = rs1_value & op_b;
      default:  alu_out = '0;
    endcase
  end

  always_comb begin
    case (dec.branch_op)
      BR_BEQ:  taken = (rs1_value == rs2_value);
      BR_BNE:  taken = (rs1_value != rs2_value);
      BR_BLT:  taken = $signed(rs1_value) < $signed(rs2_value);
      BR_BGE:  taken = $signed(rs1_value) >= $signed(rs2_value);
      BR_BLTU: taken = rs1_value < rs2_value;
      BR_BGEU: taken = rs1_value >= rs2_value;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res = '0;
    res.mem_addr = rs1_rel;
    res.target_pc = link;
    case (dec.opcode)
      OPC_LUI:   res.rd_value = dec.imm;
      OPC_AUIPC: res.rd_value = pc_rel;
      OPC_JAL: begin
        res.rd_value = link;
        res.target_pc = pc_rel;
      end
      OPC_JALR: begin
        res.rd_value = link;
        res.target_pc = {rs1_rel[`RV_XLEN-1:1], 1'b0};
      end
      OPC_BRANCH: res.target_pc = taken ? pc_rel : link;
      default:    res.rd_value = alu_out;
    endcase
    res.pc_misaligned = |res.target_pc[1:0];
    res.addr_misaligned = |res.mem_addr[1:0];
  end

endmodule

// ==== hw/rv_regfile.sv ====
`include "rv_defines.svh"

module rv_regfile (
  input  logic                clk,
  input  logic [4:0]          rs1_idx,
  input  logic [4:0]          rs2_idx,
  output logic [`RV_XLEN-1:0] rs1_value,
  output logic [`RV_XLEN-1:0] rs2_value,
  input  logic                we,
  input  logic [4:0]          rd_idx,
  input  logic [`RV_XLEN-1:0] rd_value
);

  // no storage behind x0
  logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (we && (rd_idx != 5'd0)) begin
      regs[rd_idx] <= rd_value;
    end
  end

  assign rs1_value = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
  assign rs2_value = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// ==== hw/rv_control.sv ====
`include "rv_defines.svh"

module rv_control
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  output mem_req_t            mem_req,
  input  mem_rsp_t            mem_rsp,
  input  decoded_insn_t       dec,
  input  exec_result_t        res,
  input  logic [`RV_XLEN-1:0] rs2_value,
  output logic [`RV_XLEN-1:0] insn,
  output logic [`RV_XLEN-1:0] pc,
  output logic                rd_we,
  output logic [`RV_XLEN-1:0] rd_value,
  output logic                trap
);

  cpu_state_e state;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] pc_step;
  logic [`RV_XLEN-1:0] wb_value;

  assign pc_step = pc + `RV_INSN_STEP;
  assign rd_we = (state == ST_WRITEBACK) && dec.writes_rd;
  assign rd_value = wb_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      next_pc <= `RV_RESET_PC;
      trap <= 1'b0;
      mem_req.valid <= 1'b0;
      mem_req.instr <= 1'b0;
      mem_req.wstrb <= '0;
    end else begin
      case (state)
        ST_FETCH: begin
          mem_req.valid <= 1'b1;
          mem_req.instr <= 1'b1;
          mem_req.addr <= next_pc;
          mem_req.wstrb <= '0;
          state <= ST_WAIT_INSN;
        end
        ST_WAIT_INSN: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            mem_req.instr <= 1'b0;
            insn <= mem_rsp.rdata;
            pc <= mem_req.addr;
            state <= ST_EXECUTE;
          end
        end
        ST_EXECUTE: begin
          wb_value <= res.rd_value;
          if (!dec.legal) begin
            trap <= 1'b1;
            state <= ST_TRAP;
          end else begin
            case (dec.opcode)
              OPC_JAL, OPC_JALR, OPC_BRANCH: state <= ST_CHECK_PC;
              OPC_LOAD, OPC_STORE: begin
                if (res.addr_misaligned) begin
                  trap <= 1'b1;
                  state <= ST_TRAP;
                end else begin
                  mem_req.valid <= 1'b1;
                  mem_req.instr <= 1'b0;
                  mem_req.addr <= res.mem_addr;
                  mem_req.wdata <= rs2_value;
                  mem_req.wstrb <= (dec.opcode == OPC_STORE) ? '1 : '0;
                  state <= ST_WAIT_MEM;
                end
              end
              default: begin
                next_pc <= pc_step;
                state <= ST_WRITEBACK;
              end
            endcase
          end
        end
        // jumps and branches land here so a bad target traps before any write
        ST_CHECK_PC: begin
          if (res.pc_misaligned) begin
            trap <= 1'b1;
            state <= ST_TRAP;
          end else begin
            next_pc <= res.target_pc;
            state <= (dec.opcode == OPC_BRANCH) ? ST_FETCH : ST_WRITEBACK;
          end
        end
        ST_WAIT_MEM: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            mem_req.wstrb <= '0;
            wb_value <= mem_rsp.rdata;
            next_pc <= pc_step;
            state <= (dec.opcode == OPC_STORE) ? ST_FETCH : ST_WRITEBACK;
          end
        end
        ST_WRITEBACK: state <= ST_FETCH;
        ST_TRAP:      state <= ST_TRAP;
        default:      state <= ST_TRAP;
      endcase
    end
  end

  // picorv32 rule, request frozen until ready
  req_stable_a: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && !mem_rsp.ready |=> $stable(mem_req));

  // halted core never touches the bus again
  trap_sticky_a: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap && !mem_req.valid);

  fetch_no_write_a: assert property (@(posedge clk) disable iff (reset)
    !(mem_req.valid && mem_req.instr && |mem_req.wstrb));

endmodule

// ==== hw/rv_core.sv ====
`include "rv_defines.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     trap
);

  decoded_insn_t dec;
  exec_result_t res;
  logic [`RV_XLEN-1:0] insn;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rs1_value;
  logic [`RV_XLEN-1:0] rs2_value;
  logic rd_we;
  logic [`RV_XLEN-1:0] rd_value;

  rv_decoder decoder_i (
    .insn (insn),
    .dec  (dec)
  );

  rv_execute execute_i (
    .dec       (dec),
    .pc        (pc),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .res       (res)
  );

  // write index comes straight from the held instruction
  rv_regfile regfile_i (
    .clk       (clk),
    .rs1_idx   (dec.rs1),
    .rs2_idx   (dec.rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .we        (rd_we),
    .rd_idx    (dec.rd),
    .rd_value  (rd_value)
  );

  rv_control control_i (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .dec       (dec),
    .res       (res),
    .rs2_value (rs2_value),
    .insn      (insn),
    .pc        (pc),
    .rd_we     (rd_we),
    .rd_value  (rd_value),
    .trap      (trap)
  );

endmodule

// ==== sim/rv_mem_model.sv ====
`include "rv_defines.svh"

module rv_mem_model
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     stall,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  localparam int depth = 1024;
  localparam int index_bits = $clog2(depth);

  // word array, loaded by the testbench before reset is released
  logic [`RV_XLEN-1:0] words [depth];
  logic [index_bits-1:0] index;

  assign index = mem_req.addr[index_bits+1:2];

  // ready answers a raised valid unless the testbench draws a stall
  assign mem_rsp.ready = mem_req.valid && !stall;
  assign mem_rsp.rdata = words[index];

  always @(posedge clk) begin
    if (mem_req.valid && mem_rsp.ready) begin
      for (int lane = 0; lane < `RV_XLEN / 8; lane++) begin
        if (mem_req.wstrb[lane]) begin
          words[index][lane*8 +: 8] = mem_req.wdata[lane*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== sim/rv_core_tb.sv ====
`include "rv_defines.svh"

module rv_core_tb
  import rv_pkg::*;
();

  localparam logic [3:0] alu_kinds [10] = '{4'd0, 4'd8, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5,
                                            4'd13, 4'd6, 4'd7};

  logic clk;
  logic reset;
  logic stall;
  logic trap;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  mem_req_t prev_req;
  logic prev_stalled;
  logic [31:0] rng_state;
  logic [31:0] asm_pc;
  logic [31:0] slot;
  logic [31:0] fetch_q[$];
  logic [63:0] store_q[$];
  string name_q[$];

  rv_core dut_i (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .trap    (trap)
  );

  rv_mem_model mem_i (
    .clk     (clk),
    .stall   (stall),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // kind is {funct7 bit 5, funct3}
  function automatic logic [31:0] ref_alu(input logic [3:0] kind, input logic [31:0] a,
                                          input logic [31:0] b);
    case (kind)
      4'd0:    return a + b;
      4'd8:    return a - b;
      4'd1:    return a << b[4:0];
      4'd2:    return {31'b0, $signed(a) < $signed(b)};
      4'd3:    return {31'b0, a < b};
      4'd4:    return a ^ b;
      4'd5:    return a >> b[4:0];
      4'd13:   return $signed(a) >>> b[4:0];
      4'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      abort_run($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // fetched is low for words that the program flow jumps over
  task automatic emit(input logic [31:0] word, input logic fetched);
    mem_i.words[asm_pc[11:2]] = word;
    if (fetched) begin
      fetch_q.push_back(asm_pc);
    end
    asm_pc = asm_pc + 4;
  endtask

  task automatic store_result(input logic [4:0] rs, input logic [31:0] value, input string name);
    emit(s_type(slot[11:0], rs, 5'd0, 3'b010), 1'b1);
    store_q.push_back({slot, value});
    name_q.push_back(name);
    slot = slot + 4;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, OPC_LUI), 1'b1);
    emit(i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), 1'b1);
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) begin
      @(negedge clk);
      assert (!mem_req.valid && !trap) else abort_run("valid or trap was high during reset");
    end
    reset = 1'b0;
  endtask

  task automatic wait_trap(input int limit);
    int cycles;
    cycles = 0;
    while (!trap) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run("timed out waiting for the core to trap");
      end
    end
    repeat (20) begin
      @(negedge clk);
      assert (trap && !mem_req.valid) else abort_run("bus became active after the trap");
    end
  endtask

  task automatic run_trap(input logic [31:0] word);
    fetch_q.delete();
    store_q.delete();
    name_q.delete();
    asm_pc = `RV_RESET_PC;
    emit(word, 1'b1);
    apply_reset();
    wait_trap(200);
    assert (fetch_q.size() == 0) else abort_run("faulting instruction was never fetched");
  endtask

  // random ready stalls, about one cycle in four
  always @(negedge clk) begin
    stall = (next_rand() & 32'h3) == 32'h0;
  end

  always @(posedge clk) begin
    logic [63:0] entry;
    if (reset) begin
      prev_stalled = 1'b0;
    end else begin
      if (prev_stalled) begin
        assert (mem_req === prev_req) else abort_run("request changed while ready was low");
      end
      if (mem_req.valid && mem_rsp.ready && mem_req.instr) begin
        assert (fetch_q.size() > 0) else abort_run("fetch outside the expected program flow");
        check_value("fetch address", fetch_q.pop_front(), mem_req.addr);
      end else if (mem_req.valid && mem_rsp.ready && mem_req.wstrb != 4'h0) begin
        assert (store_q.size() > 0) else abort_run("store that the program does not contain");
        entry = store_q.pop_front();
        check_value({name_q[0], " strobe"}, 32'hf, {28'b0, mem_req.wstrb});
        check_value({name_q[0], " address"}, entry[63:32], mem_req.addr);
        check_value(name_q.pop_front(), entry[31:0], mem_req.wdata);
      end
      prev_stalled = mem_req.valid && !mem_rsp.ready;
      prev_req = mem_req;
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] base;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic taken;
    reset = 1'b1;
    stall = 1'b0;
    prev_stalled = 1'b0;
    rng_state = 32'h4b23_af58;
    asm_pc = `RV_RESET_PC;
    slot = 32'h400;
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    foreach (alu_kinds[k]) begin
      emit(r_type({1'b0, alu_kinds[k][3], 5'b0}, 5'd2, 5'd1, alu_kinds[k][2:0], 5'd3), 1'b1);
      store_result(5'd3, ref_alu(alu_kinds[k], a, b), $sformatf("alu reg %0d", alu_kinds[k]));
      if (alu_kinds[k] != 4'd8) begin
        imm = next_rand();
        imm = {{20{imm[11]}}, imm[11:0]};
        // shifts carry only shamt plus the arithmetic bit
        if (alu_kinds[k][1:0] == 2'b01) begin
          imm = {21'b0, alu_kinds[k][3], 5'b0, imm[4:0]};
        end
        emit(i_type(imm[11:0], 5'd1, alu_kinds[k][2:0], 5'd3, OPC_OP_IMM), 1'b1);
        store_result(5'd3, ref_alu(alu_kinds[k], a, imm), $sformatf("alu imm %0d", alu_kinds[k]));
      end
    end
    // pairs (x1,x2), (x2,x1), (x1,x1) give both outcomes for every branch kind
    for (int p = 0; p < 3; p++) begin
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          rs1 = (p == 1) ? 5'd2 : 5'd1;
          rs2 = (p == 0) ? 5'd2 : 5'd1;
          taken = ref_taken(f[2:0], (rs1 == 5'd1) ? a : b, (rs2 == 5'd1) ? a : b);
          emit(i_type(12'd2, 5'd0, 3'b000, 5'd5, OPC_OP_IMM), 1'b1);
          emit(b_type(13'd8, rs2, rs1, f[2:0]), 1'b1);
          emit(i_type(12'd1, 5'd0, 3'b000, 5'd5, OPC_OP_IMM), !taken);
          store_result(5'd5, taken ? 32'd2 : 32'd1, $sformatf("branch %0d pair %0d", f, p));
        end
      end
    end
    base = asm_pc;
    emit(j_type(21'd8, 5'd6), 1'b1);
    emit(32'h0, 1'b0);
    store_result(5'd6, base + 4, "jal link");
    base = asm_pc;
    emit(i_type(base[11:0] + 12'd12, 5'd0, 3'b000, 5'd7, OPC_OP_IMM), 1'b1);
    emit(i_type(12'd1, 5'd7, 3'b000, 5'd8, OPC_JALR), 1'b1);
    emit(32'h0, 1'b0);
    store_result(5'd8, base + 8, "jalr link");
    base = slot;
    store_result(5'd1, a, "word store");
    emit(i_type(base[11:0], 5'd0, 3'b010, 5'd9, OPC_LOAD), 1'b1);
    store_result(5'd9, a, "word load");
    base = asm_pc;
    imm = next_rand();
    emit(u_type(imm[19:0], 5'd10, OPC_AUIPC), 1'b1);
    store_result(5'd10, base + {imm[19:0], 12'b0}, "auipc");
    // ecall ends the program in the trap state
    emit(32'h0000_0073, 1'b1);
    apply_reset();
    wait_trap(20000);
    assert (fetch_q.size() == 0 && store_q.size() == 0) else begin
      abort_run("program stopped before its last instruction");
    end
    // misaligned word load, then a byte store
    run_trap(i_type(12'd2, 5'd0, 3'b010, 5'd1, OPC_LOAD));
    run_trap(s_type(12'd0, 5'd0, 5'd0, 3'b000));
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_control.sv
hw/rv_core.sv
sim/rv_mem_model.sv
sim/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/rv_decoder.sv
      - hw/rv_execute.sv
      - hw/rv_regfile.sv
      - hw/rv_control.sv
      - hw/rv_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/rv_mem_model.sv
      - sim/rv_core_tb.sv
